/* Bender.yml */
package:
  name: fetchUnit

sources:
  - hw/fetchPkg.sv
  - hw/btb.sv
  - hw/branchPredictor.sv
  - hw/ras.sv
  - hw/fetchStage1.sv
  - hw/fetchQueue.sv
  - hw/fetchStage2.sv
  - hw/fetchUnit.sv
  - target: test
    files:
      - tb/fetchUnit_properties.sv
      - tb/fetchUnitTb.sv

/* fetchUnit.f */
hw/fetchPkg.sv
hw/btb.sv
hw/branchPredictor.sv
hw/ras.sv
hw/fetchStage1.sv
hw/fetchQueue.sv
hw/fetchStage2.sv
hw/fetchUnit.sv
tb/fetchUnit_properties.sv
tb/fetchUnitTb.sv

/* hw/branchPredictor.sv */
// ------------------------------
// bimodal direction predictor
// two-bit counters, four reads
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module branchPredictor #(
  parameter int bpEntries = 256
) (
  input  wire logic                            clk,
  input  wire logic                            reset,
  input  wire logic [fetchPkg::pcWidth-1:0]    pc_i,
  input  wire fetchPkg::branchUpdate           update_i,
  output logic [fetchPkg::fetchWidth-1:0]      taken_o
);

  localparam int idxBits = $clog2(bpEntries);

  logic [1:0]         counter [bpEntries];
  logic [idxBits-1:0] wrIdx;

  assign wrIdx = update_i.pc[idxBits+1:2];

  // counters start weakly not-taken and saturate at both ends.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < bpEntries; i++) begin
        counter[i] <= 2'b01;
      end
    end else if (update_i.en) begin
      if (update_i.taken && counter[wrIdx] != 2'b11) begin
        counter[wrIdx] <= counter[wrIdx] + 2'b01;
      end else if (!update_i.taken && counter[wrIdx] != 2'b00) begin
        counter[wrIdx] <= counter[wrIdx] - 2'b01;
      end
    end
  end

  // upper counter bit is the prediction.
  for (genvar k = 0; k < fetchPkg::fetchWidth; k++) begin : gSlot
    logic [fetchPkg::pcWidth-1:0] slotPc;
    assign slotPc     = pc_i + fetchPkg::pcWidth'(4 * k);
    assign taken_o[k] = counter[slotPc[idxBits+1:2]][1];
  end

endmodule

`default_nettype wire

/* hw/btb.sv */
// ------------------------------
// branch target buffer
// direct mapped, four read ports
// and one write port
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module btb #(
  parameter int btbEntries = 64
) (
  input  wire logic                                              clk,
  input  wire logic                                              reset,
  input  wire logic [fetchPkg::pcWidth-1:0]                      pc_i,
  input  wire fetchPkg::branchUpdate                             update_i,
  output logic [fetchPkg::fetchWidth-1:0]                        hit_o,
  output fetchPkg::brType [fetchPkg::fetchWidth-1:0]             type_o,
  output logic [fetchPkg::fetchWidth-1:0][fetchPkg::pcWidth-1:0] target_o
);

  // index comes from the word address, tag is everything above it.
  localparam int idxBits = $clog2(btbEntries);
  localparam int tagBits = fetchPkg::pcWidth - idxBits - 2;

  logic [btbEntries-1:0] validQ;
  logic [tagBits-1:0]    tagMem [btbEntries];
  fetchPkg::brType       typeMem [btbEntries];
  logic [fetchPkg::pcWidth-1:0] targetMem [btbEntries];

  logic [idxBits-1:0] wrIdx;
  assign wrIdx = update_i.pc[idxBits+1:2];

  // valid bits are the only state cleared on reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      validQ <= '0;
    end else if (update_i.en) begin
      validQ[wrIdx] <= 1'b1;
    end
  end

  // an update simply replaces the whole entry.
  always_ff @(posedge clk) begin
    if (update_i.en) begin
      tagMem[wrIdx]    <= update_i.pc[fetchPkg::pcWidth-1:idxBits+2];
      typeMem[wrIdx]   <= update_i.ctrlType;
      targetMem[wrIdx] <= update_i.target;
    end
  end

  // one lookup per slot, slot k sits at pc + 4k.
  for (genvar k = 0; k < fetchPkg::fetchWidth; k++) begin : gSlot
    logic [fetchPkg::pcWidth-1:0] slotPc;
    logic [idxBits-1:0]           rdIdx;

    assign slotPc = pc_i + fetchPkg::pcWidth'(4 * k);
    assign rdIdx  = slotPc[idxBits+1:2];

    // hit needs a valid entry with a matching tag.
    assign hit_o[k]    = validQ[rdIdx] &&
                         (tagMem[rdIdx] == slotPc[fetchPkg::pcWidth-1:idxBits+2]);
    assign type_o[k]   = typeMem[rdIdx];
    assign target_o[k] = targetMem[rdIdx];
  end

endmodule

`default_nettype wire

/* hw/fetchPkg.sv */
// ------------------------------
// fetch package
// widths, branch types and the
// packet structs of the fetch unit
// ------------------------------
`default_nettype none

package fetchPkg;

  // address and instruction widths.
  localparam int pcWidth = 32;
  localparam int instWidth = 32;
  // slots per fetch bundle.
  localparam int fetchWidth = 4;
  localparam int slotBits = $clog2(fetchWidth);

  // control instruction type.
  typedef enum logic [1:0] {
    ret  = 2'b00,
    call = 2'b01,
    jump = 2'b10,
    cond = 2'b11
  } brType;

  // one bundle as held in the fetch queue.
  typedef struct packed {
    logic [pcWidth-1:0]                    pc;
    logic [fetchWidth-1:0][instWidth-1:0]  inst;
    logic [fetchWidth-1:0]                 btbHit;
    logic [fetchWidth-1:0]                 predTaken;
    logic [pcWidth-1:0]                    nextPc;
    logic                                  taken;
    logic [slotBits-1:0]                   takenSlot;
  } fetchPacket;

  // bundle handed to decode.
  typedef struct packed {
    logic                                  valid;
    logic [pcWidth-1:0]                    pc;
    logic [fetchWidth-1:0][instWidth-1:0]  inst;
    logic [fetchWidth-1:0]                 slotValid;
    logic [pcWidth-1:0]                    nextPc;
  } decodePacket;

  // resolved branch, sent back for training.
  typedef struct packed {
    logic               en;
    logic [pcWidth-1:0] pc;
    logic [pcWidth-1:0] target;
    brType              ctrlType;
    logic               taken;
  } branchUpdate;

  // redirect from execute or decode.
  typedef struct packed {
    logic               exFlag;
    logic [pcWidth-1:0] exTarget;
    logic               idFlag;
    logic [pcWidth-1:0] idTarget;
  } recoverInfo;

endpackage

`default_nettype wire

/* hw/fetchQueue.sv */
// ------------------------------
// fetch queue
// circular buffer of bundles
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module fetchQueue #(
  parameter int queueDepth = 4
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 flush_i,
  input  wire logic                 push_i,
  input  wire fetchPkg::fetchPacket data_i,
  input  wire logic                 pop_i,
  output fetchPkg::fetchPacket      data_o,
  output logic                      empty_o,
  output logic                      full_o
);

  localparam int ptrBits = $clog2(queueDepth);

  fetchPkg::fetchPacket mem [queueDepth];
  logic [ptrBits-1:0]   rdPtr;
  logic [ptrBits-1:0]   wrPtr;
  logic [ptrBits:0]     count;
  logic                 doPush;
  logic                 doPop;

  assign full_o  = (count == (ptrBits + 1)'(queueDepth));
  assign empty_o = (count == '0);
  assign doPush  = push_i && !full_o;
  assign doPop   = pop_i && !empty_o;

  // flush drops everything at the edge.
  always_ff @(posedge clk) begin
    if (reset || flush_i) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;
      if (doPop)  rdPtr <= rdPtr + 1'b1;
      count <= count + (ptrBits + 1)'(doPush) - (ptrBits + 1)'(doPop);
    end
  end

  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= data_i;
  end

  // head is read without a register.
  assign data_o = mem[rdPtr];

endmodule

`default_nettype wire

/* hw/fetchStage1.sv */
// ------------------------------
// fetch stage 1
// pc register, branch lookup and
// next pc selection
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module fetchStage1 #(
  parameter int btbEntries = 64,
  parameter int bpEntries  = 256,
  parameter int rasDepth   = 8
) (
  input  wire logic                                                clk,
  input  wire logic                                                reset,
  input  wire fetchPkg::recoverInfo                                recover_i,
  input  wire fetchPkg::branchUpdate                               update_i,
  input  wire logic [fetchPkg::fetchWidth-1:0][fetchPkg::instWidth-1:0] instBundle_i,
  input  wire logic                                                full_i,
  output logic [fetchPkg::pcWidth-1:0]                             fetchPc_o,
  output fetchPkg::fetchPacket                                     packet_o,
  output logic                                                     push_o,
  output logic                                                     flush_o
);

  logic [fetchPkg::pcWidth-1:0] pcQ;
  logic [fetchPkg::pcWidth-1:0] nextPc;
  logic [fetchPkg::pcWidth-1:0] rasTop;
  logic [fetchPkg::pcWidth-1:0] rasPushAddr;
  logic rasPush;
  logic rasPop;

  logic [fetchPkg::fetchWidth-1:0]                        btbHit;
  fetchPkg::brType [fetchPkg::fetchWidth-1:0]             btbType;
  logic [fetchPkg::fetchWidth-1:0][fetchPkg::pcWidth-1:0] btbTarget;
  logic [fetchPkg::fetchWidth-1:0]                        bpTaken;
  logic [fetchPkg::fetchWidth-1:0]                        predTaken;

  logic                          anyTaken;
  logic [fetchPkg::slotBits-1:0] firstSlot;
  fetchPkg::brType               firstType;

  fetchPkg::branchUpdate btbUpdate;
  fetchPkg::branchUpdate bpUpdate;

  // predictor trains on cond only.
  // btb skips a cond that fell through.
  always_comb begin
    btbUpdate    = update_i;
    bpUpdate     = update_i;
    btbUpdate.en = update_i.en &&
                   (update_i.ctrlType != fetchPkg::cond || update_i.taken);
    bpUpdate.en  = update_i.en && (update_i.ctrlType == fetchPkg::cond);
  end

  btb #(.btbEntries(btbEntries)) uBtb (
    .clk(clk), .reset(reset), .pc_i(pcQ), .update_i(btbUpdate),
    .hit_o(btbHit), .type_o(btbType), .target_o(btbTarget)
  );

  branchPredictor #(.bpEntries(bpEntries)) uBp (
    .clk(clk), .reset(reset), .pc_i(pcQ), .update_i(bpUpdate),
    .taken_o(bpTaken)
  );

  ras #(.rasDepth(rasDepth)) uRas (
    .clk(clk), .reset(reset), .push_i(rasPush), .pushAddr_i(rasPushAddr),
    .pop_i(rasPop), .top_o(rasTop)
  );

  // a hit redirects if predicted taken or not conditional.
  for (genvar k = 0; k < fetchPkg::fetchWidth; k++) begin : gTaken
    assign predTaken[k] = btbHit[k] && (bpTaken[k] || btbType[k] != fetchPkg::cond);
  end

  // lowest taken slot wins, so scan from the top down.
  always_comb begin
    anyTaken  = 1'b0;
    firstSlot = '0;
    for (int k = fetchPkg::fetchWidth - 1; k >= 0; k--) begin
      if (predTaken[k]) begin
        anyTaken  = 1'b1;
        firstSlot = fetchPkg::slotBits'(k);
      end
    end
  end

  assign firstType = btbType[firstSlot];

  // returns take the stack top, everything else the btb target.
  always_comb begin
    nextPc = pcQ + fetchPkg::pcWidth'(4 * fetchPkg::fetchWidth);
    if (anyTaken) begin
      nextPc = (firstType == fetchPkg::ret) ? rasTop : btbTarget[firstSlot];
    end
  end

  assign flush_o = recover_i.exFlag || recover_i.idFlag;
  assign push_o  = !reset && !flush_o && !full_i;

  // stack moves only when the bundle really enters the queue.
  assign rasPush     = push_o && anyTaken && (firstType == fetchPkg::call);
  assign rasPop      = push_o && anyTaken && (firstType == fetchPkg::ret);
  assign rasPushAddr = pcQ + fetchPkg::pcWidth'({firstSlot, 2'b00}) + 32'd4;

  // execute recovery over decode recovery over prediction.
  always_ff @(posedge clk) begin
    if (reset) begin
      pcQ <= '0;
    end else if (recover_i.exFlag) begin
      pcQ <= recover_i.exTarget;
    end else if (recover_i.idFlag) begin
      pcQ <= recover_i.idTarget;
    end else if (!full_i) begin
      pcQ <= nextPc;
    end
  end

  assign fetchPc_o = pcQ;

  always_comb begin
    packet_o.pc        = pcQ;
    packet_o.inst      = instBundle_i;
    packet_o.btbHit    = btbHit;
    packet_o.predTaken = predTaken;
    packet_o.nextPc    = nextPc;
    packet_o.taken     = anyTaken;
    packet_o.takenSlot = firstSlot;
  end

endmodule

`default_nettype wire

/* hw/fetchStage2.sv */
// ------------------------------
// fetch stage 2
// pops bundles, masks off-path
// slots, feeds decode
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module fetchStage2 (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 flush_i,
  input  wire logic                 decodeReady_i,
  input  wire fetchPkg::fetchPacket head_i,
  input  wire logic                 empty_i,
  output logic                      pop_o,
  output fetchPkg::decodePacket     decodePacket_o
);

  fetchPkg::decodePacket          decodeQ;
  logic [fetchPkg::fetchWidth-1:0] slotMask;

  // never hand over a bundle from the wrong path.
  assign pop_o = decodeReady_i && !empty_i && !flush_i;

  // slots up to and including the first taken one.
  always_comb begin
    for (int k = 0; k < fetchPkg::fetchWidth; k++) begin
      slotMask[k] = !head_i.taken || (k <= int'(head_i.takenSlot));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      decodeQ.valid <= 1'b0;
    end else begin
      decodeQ.valid <= pop_o;
      if (pop_o) begin
        decodeQ.pc        <= head_i.pc;
        decodeQ.inst      <= head_i.inst;
        decodeQ.slotValid <= slotMask;
        decodeQ.nextPc    <= head_i.nextPc;
      end
    end
  end

  assign decodePacket_o = decodeQ;

endmodule

`default_nettype wire

/* hw/fetchUnit.sv */
// ------------------------------
// fetch unit top level
// stage 1, fetch queue, stage 2
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module fetchUnit #(
  parameter int btbEntries = 64,
  parameter int bpEntries  = 256,
  parameter int rasDepth   = 8,
  parameter int queueDepth = 4
) (
  input  wire logic                                                clk,
  input  wire logic                                                reset,
  input  wire fetchPkg::recoverInfo                                recover_i,
  input  wire fetchPkg::branchUpdate                               branchUpdate_i,
  input  wire logic [fetchPkg::fetchWidth-1:0][fetchPkg::instWidth-1:0] instBundle_i,
  input  wire logic                                                decodeReady_i,
  output logic [fetchPkg::pcWidth-1:0]                             fetchPc_o,
  output fetchPkg::decodePacket                                    decodePacket_o
);

  fetchPkg::fetchPacket pushPacket;
  fetchPkg::fetchPacket headPacket;
  logic push;
  logic pop;
  logic flush;
  logic full;
  logic empty;

  fetchStage1 #(.btbEntries(btbEntries), .bpEntries(bpEntries), .rasDepth(rasDepth)) uFs1 (
    .clk(clk), .reset(reset), .recover_i(recover_i), .update_i(branchUpdate_i),
    .instBundle_i(instBundle_i), .full_i(full), .fetchPc_o(fetchPc_o),
    .packet_o(pushPacket), .push_o(push), .flush_o(flush)
  );

  // flush reaches queue and stage 2 in the same cycle.
  fetchQueue #(.queueDepth(queueDepth)) uQueue (
    .clk(clk), .reset(reset), .flush_i(flush), .push_i(push), .data_i(pushPacket),
    .pop_i(pop), .data_o(headPacket), .empty_o(empty), .full_o(full)
  );

  fetchStage2 uFs2 (
    .clk(clk), .reset(reset), .flush_i(flush), .decodeReady_i(decodeReady_i),
    .head_i(headPacket), .empty_i(empty), .pop_o(pop), .decodePacket_o(decodePacket_o)
  );

endmodule

`default_nettype wire

/* hw/ras.sv */
// ------------------------------
// return address stack
// circular, oldest entry is lost
// on overflow
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module ras #(
  parameter int rasDepth = 8
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         push_i,
  input  wire logic [fetchPkg::pcWidth-1:0] pushAddr_i,
  input  wire logic                         pop_i,
  output logic [fetchPkg::pcWidth-1:0]      top_o
);

  localparam int ptrBits = $clog2(rasDepth);
  localparam logic [ptrBits:0] maxCount = (ptrBits + 1)'(rasDepth);

  logic [fetchPkg::pcWidth-1:0] stack [rasDepth];
  logic [ptrBits-1:0]           topPtr;
  logic [ptrBits-1:0]           nextPtr;
  logic [ptrBits:0]             count;

  assign nextPtr = topPtr + 1'b1;

  // pointer wraps, count saturates at the depth.
  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
      count  <= '0;
    end else if (push_i) begin
      topPtr <= nextPtr;
      if (count != maxCount) begin
        count <= count + 1'b1;
      end
    end else if (pop_i && count != '0) begin
      topPtr <= topPtr - 1'b1;
      count  <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      stack[nextPtr] <= pushAddr_i;
    end
  end

  // empty stack reads as zero.
  assign top_o = (count == '0) ? '0 : stack[topPtr];

endmodule

`default_nettype wire

/* tb/fetchUnitTb.sv */
// ------------------------------
// fetch unit testbench
// memory model, branch training,
// reference model and checks
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module fetchUnitTb;

  localparam int cycleLimit = 4000;

  logic clk;
  logic reset;
  fetchPkg::recoverInfo  recover;
  fetchPkg::branchUpdate update;
  logic [fetchPkg::fetchWidth-1:0][fetchPkg::instWidth-1:0] instBundle;
  logic decodeReady;
  logic [fetchPkg::pcWidth-1:0] fetchPc;
  fetchPkg::decodePacket decodePacket;

  // trained branches as the reference model sees them.
  logic [31:0]     brPc [8];
  fetchPkg::brType brKind [8];
  logic [31:0]     brTarget [8];
  logic [1:0]      brCounter [8];
  logic            brInBtb [8];
  int              numBr;
  logic [31:0]     rasModel [$];
  logic [31:0]     expPc;
  int              delivered;
  int              cycles;
  string           testName;

  fetchUnit dut (
    .clk(clk), .reset(reset), .recover_i(recover), .branchUpdate_i(update),
    .instBundle_i(instBundle), .decodeReady_i(decodeReady),
    .fetchPc_o(fetchPc), .decodePacket_o(decodePacket)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // each word carries the address it was fetched from.
  function automatic logic [31:0] instWord(input logic [31:0] addr);
    return addr ^ 32'hA500_0000;
  endfunction

  // memory answers in the same cycle.
  always_comb begin
    for (int k = 0; k < fetchPkg::fetchWidth; k++) begin
      instBundle[k] = instWord(fetchPc + 32'(4 * k));
    end
  end

  task automatic stopOnError(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (expected === actual) else
      stopOnError($sformatf("ERR %s %s: expected %h actual %h",
                            testName, what, expected, actual));
  endtask

  function automatic int findBranch(input logic [31:0] pc);
    for (int i = 0; i < numBr; i++) begin
      if (brPc[i] == pc) begin
        return i;
      end
    end
    return -1;
  endfunction

  // expected mask and next pc for the bundle at expPc.
  task automatic checkPacket();
    logic [31:0] nextExp;
    logic [3:0]  mask;
    int          idx;
    int          first;
    first   = -1;
    mask    = 4'b1111;
    nextExp = expPc + 32'd16;
    for (int k = 0; k < fetchPkg::fetchWidth; k++) begin
      idx = findBranch(expPc + 32'(4 * k));
      if (first < 0 && idx >= 0 && brInBtb[idx] &&
          (brKind[idx] != fetchPkg::cond || brCounter[idx][1])) begin
        first = idx;
        mask  = 4'((1 << (k + 1)) - 1);
      end
    end
    checkValue("pc", expPc, decodePacket.pc);
    for (int k = 0; k < fetchPkg::fetchWidth; k++) begin
      checkValue("inst", instWord(expPc + 32'(4 * k)), decodePacket.inst[k]);
    end
    checkValue("slotValid", 32'(mask), 32'(decodePacket.slotValid));
    if (first >= 0 && brKind[first] == fetchPkg::ret) begin
      // empty stack gives zero.
      nextExp = (rasModel.size() > 0) ? rasModel[$] : 32'd0;
      if (rasModel.size() > 0) begin
        void'(rasModel.pop_back());
      end
    end else if (first >= 0) begin
      nextExp = brTarget[first];
      if (brKind[first] == fetchPkg::call) begin
        rasModel.push_back(brPc[first] + 32'd4);
      end
    end
    checkValue("nextPc", nextExp, decodePacket.nextPc);
    expPc = nextExp;
    delivered++;
  endtask

  // decode packet is stable by the falling edge.
  always @(negedge clk) begin
    if (!reset && decodePacket.valid) begin
      checkPacket();
    end
  end

  // run limit and bound queue assertions.
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      stopOnError("timeout: run went past the cycle limit");
    end else if (dut.uQueue.props.failCount != 0) begin
      stopOnError("a fetch queue assertion failed");
    end
  end

  task automatic waitPackets(input int n);
    int target;
    target = delivered + n;
    while (delivered < target) begin
      @(negedge clk);
    end
  endtask

  // decode stops taking bundles until the queue is full.
  task automatic stallUntilFull();
    decodeReady = 1'b0;
    @(negedge clk);
    while (!dut.uQueue.full_o) begin
      @(negedge clk);
    end
  endtask

  // one resolved branch, mirrored into the model.
  task automatic train(input logic [31:0] pc, input fetchPkg::brType kind,
                       input logic [31:0] target, input logic taken);
    int idx;
    idx = findBranch(pc);
    if (idx < 0) begin
      idx = numBr;
      numBr++;
      brPc[idx]      = pc;
      brCounter[idx] = 2'b01;
      brInBtb[idx]   = 1'b0;
    end
    // not-taken cond leaves the btb alone.
    if (kind != fetchPkg::cond || taken) begin
      brInBtb[idx]  = 1'b1;
      brKind[idx]   = kind;
      brTarget[idx] = target;
    end
    if (kind == fetchPkg::cond && taken && brCounter[idx] != 2'b11) begin
      brCounter[idx] = brCounter[idx] + 2'b01;
    end else if (kind == fetchPkg::cond && !taken && brCounter[idx] != 2'b00) begin
      brCounter[idx] = brCounter[idx] - 2'b01;
    end
    update.en       = 1'b1;
    update.pc       = pc;
    update.target   = target;
    update.ctrlType = kind;
    update.taken    = taken;
    @(negedge clk);
    update.en = 1'b0;
  endtask

  // execute target beats decode target.
  task automatic redirect(input logic ex, input logic [31:0] exTarget,
                          input logic id, input logic [31:0] idTarget);
    recover.exFlag   = ex;
    recover.exTarget = exTarget;
    recover.idFlag   = id;
    recover.idTarget = idTarget;
    @(negedge clk);
    recover = '0;
    expPc   = ex ? exTarget : idTarget;
  endtask

  initial begin
    void'($urandom(38));
    reset       = 1'b1;
    recover     = '0;
    update      = '0;
    decodeReady = 1'b0;
    expPc       = '0;
    delivered   = 0;
    numBr       = 0;
    cycles      = 0;
    testName    = "sequential";
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    checkValue("valid after reset", 32'd0, 32'(decodePacket.valid));
    decodeReady = 1'b1;
    waitPackets(12);

    // jump at 0x1034, target 0x1500.
    testName = "btb jump";
    stallUntilFull();
    train(32'h1034, fetchPkg::jump, 32'h1500, 1'b1);
    redirect(1'b1, 32'h1000, 1'b0, 32'h0);
    decodeReady = 1'b1;
    waitPackets(8);

    testName = "cond taken";
    stallUntilFull();
    train(32'h3028, fetchPkg::cond, 32'h3400, 1'b1);
    train(32'h3028, fetchPkg::cond, 32'h3400, 1'b1);
    redirect(1'b1, 32'h3000, 1'b0, 32'h0);
    decodeReady = 1'b1;
    waitPackets(6);
    testName = "cond not taken";
    stallUntilFull();
    train(32'h3028, fetchPkg::cond, 32'h3400, 1'b0);
    train(32'h3028, fetchPkg::cond, 32'h3400, 1'b0);
    redirect(1'b1, 32'h3000, 1'b0, 32'h0);
    decodeReady = 1'b1;
    waitPackets(6);

    // call at 0x2008 into 0x1800, return at 0x1804.
    testName = "call return";
    stallUntilFull();
    train(32'h2008, fetchPkg::call, 32'h1800, 1'b1);
    train(32'h1804, fetchPkg::ret, 32'h0, 1'b1);
    redirect(1'b1, 32'h1FE0, 1'b0, 32'h0);
    decodeReady = 1'b1;
    waitPackets(8);

    testName = "ex over id";
    waitPackets(2);
    redirect(1'b1, 32'h5000, 1'b1, 32'h6000);
    waitPackets(4);
    testName = "id recovery";
    redirect(1'b0, 32'h0, 1'b1, 32'h7000);
    waitPackets(4);

    testName = "back pressure";
    stallUntilFull();
    repeat (10) @(negedge clk);
    for (int i = 0; i < 900; i++) begin
      decodeReady = ($urandom % 4) != 0;
      @(negedge clk);
    end
    decodeReady = 1'b1;
    waitPackets(4);

    if (dut.uQueue.props.failCount == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* tb/fetchUnit_properties.sv */
// ------------------------------
// fetch queue properties
// push, pop, flush and occupancy
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module fetchUnitProperties #(
  parameter int queueDepth = 4
) (
  input wire logic                          clk,
  input wire logic                          reset,
  input wire logic                          flush_i,
  input wire logic                          push_i,
  input wire logic                          pop_i,
  input wire logic                          empty_i,
  input wire logic                          full_i,
  input wire logic [$clog2(queueDepth):0]   count_i
);

  // failures so far, polled by the testbench.
  int unsigned failCount = 0;

  // stage 1 holds its pc while full.
  pushWhenFull: assert property (@(posedge clk) disable iff (reset) push_i |-> !full_i)
    else begin
      failCount++;
      $error("push while queue full");
    end

  popWhenEmpty: assert property (@(posedge clk) disable iff (reset) pop_i |-> !empty_i)
    else begin
      failCount++;
      $error("pop while queue empty");
    end

  // flush drops every bundle at its edge.
  emptyAfterFlush: assert property (@(posedge clk) disable iff (reset) flush_i |=> empty_i)
    else begin
      failCount++;
      $error("queue not empty after flush");
    end

  countInRange: assert property (@(posedge clk) disable iff (reset) count_i <= queueDepth)
    else begin
      failCount++;
      $error("queue count above depth");
    end

endmodule

bind fetchQueue fetchUnitProperties #(.queueDepth(queueDepth)) props (
  .clk(clk), .reset(reset), .flush_i(flush_i), .push_i(push_i), .pop_i(pop_i),
  .empty_i(empty_o), .full_i(full_o), .count_i(count)
);

`default_nettype wire
